// File: source/rv_settings.svh
/* Core width, register count and first fetch address
   Shared by the packages and the RTL modules */

`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data and address width
`define RV_XLEN 32

// Architectural integer registers
`define RV_NUM_REGS 32

// Address of the first fetch after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: source/rv_isa_pkg.sv
/* RV32I encoding types: word, register index, major opcodes,
   funct3 codes and instruction field positions */

`default_nettype none

`include "rv_settings.svh"

package rv_isa_pkg;

   typedef logic [`RV_XLEN-1:0] word_t;
   typedef logic [4:0]          reg_idx_t;

   // Major opcodes, instr[6:0]
   typedef enum logic [6:0] {
      OPC_LOAD   = 7'b0000011,
      OPC_OP_IMM = 7'b0010011,
      OPC_AUIPC  = 7'b0010111,
      OPC_STORE  = 7'b0100011,
      OPC_OP     = 7'b0110011,
      OPC_LUI    = 7'b0110111,
      OPC_BRANCH = 7'b1100011,
      OPC_JALR   = 7'b1100111,
      OPC_JAL    = 7'b1101111
   } opcode_e;

   // ALU and branch groups reuse the same code points
   typedef logic [2:0] funct3_e;

   // ==============================
   // ALU group
   localparam funct3_e F3_ADD  = 3'b000;
   localparam funct3_e F3_SLL  = 3'b001;
   localparam funct3_e F3_SLT  = 3'b010;
   localparam funct3_e F3_SLTU = 3'b011;
   localparam funct3_e F3_XOR  = 3'b100;
   localparam funct3_e F3_SR   = 3'b101;
   localparam funct3_e F3_OR   = 3'b110;
   localparam funct3_e F3_AND  = 3'b111;

   // ==============================
   // Branch group
   localparam funct3_e F3_BEQ  = 3'b000;
   localparam funct3_e F3_BNE  = 3'b001;
   localparam funct3_e F3_BLT  = 3'b100;
   localparam funct3_e F3_BGE  = 3'b101;
   localparam funct3_e F3_BLTU = 3'b110;
   localparam funct3_e F3_BGEU = 3'b111;

   // Word access for LW and SW
   localparam funct3_e F3_WORD = 3'b010;

   // SUB and SRA/SRAI
   localparam logic [6:0] F7_ALT = 7'b0100000;

   // Field positions
   localparam int RD_LSB     = 7;
   localparam int FUNCT3_LSB = 12;
   localparam int RS1_LSB    = 15;
   localparam int RS2_LSB    = 20;
   localparam int FUNCT7_LSB = 25;

endpackage

`default_nettype wire

// File: source/rv_ctrl_pkg.sv
/* Internal control types: ALU operation, operand and write-back
   selects, next-PC select and sequencer state */

`default_nettype none

package rv_ctrl_pkg;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
      ALU_EQ, ALU_NE, ALU_GE, ALU_GEU
   } alu_op_e;

   // LUI adds its immediate to zero
   typedef enum logic [1:0] {PORTA_RS1, PORTA_PC, PORTA_ZERO} porta_sel_e;

   typedef enum logic [2:0] {
      PORTB_RS2, PORTB_IMM_I, PORTB_IMM_S, PORTB_IMM_U, PORTB_IMM_J
   } portb_sel_e;

   typedef enum logic [1:0] {WB_ALU, WB_PC_PLUS4, WB_LOAD} wb_sel_e;

   typedef enum logic [1:0] {
      PC_SEL_PLUS4, PC_SEL_BRANCH, PC_SEL_JAL, PC_SEL_JALR
   } pc_sel_e;

   typedef enum logic [1:0] {ST_FETCH, ST_EXECUTE, ST_MEMORY} state_e;

endpackage

`default_nettype wire

// File: source/rv_regfile.sv
/* Register file: two combinational reads, one clocked write,
   x0 hardwired to zero */

`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_regfile
   import rv_isa_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  reg_idx_t rs1,
   input  reg_idx_t rs2,
   input  reg_idx_t rd,
   input  logic     wr_en,
   input  word_t    wr_data,
   output word_t    rs1_data,
   output word_t    rs2_data
);

   word_t regs [`RV_NUM_REGS];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `RV_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && (rd != '0)) begin
         regs[rd] <= wr_data;
      end
   end

   assign rs1_data = regs[rs1];
   assign rs2_data = regs[rs2];

   // x0 stays zero whatever the decoder writes to it
   x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (rs1 == '0) |-> (rs1_data == '0));

endmodule

`default_nettype wire

// File: source/rv_alu.sv
/* ALU: arithmetic, logic, shifts and compares,
   plus the branch condition */

`timescale 1ns/1ps
`default_nettype none

module rv_alu
   import rv_isa_pkg::*;
   import rv_ctrl_pkg::*;
(
   input  alu_op_e alu_op,
   input  word_t   operand_a,
   input  word_t   operand_b,
   output word_t   alu_res,
   output logic    cond
);

   logic [4:0] shamt;
   logic       eq;
   logic       lt_s;
   logic       lt_u;

   assign shamt = operand_b[4:0];
   assign eq    = (operand_a == operand_b);
   assign lt_s  = ($signed(operand_a) < $signed(operand_b));
   assign lt_u  = (operand_a < operand_b);

   // Branch outcome
   always_comb begin
      case (alu_op)
         ALU_EQ:   cond = eq;
         ALU_NE:   cond = ~eq;
         ALU_SLT:  cond = lt_s;
         ALU_GE:   cond = ~lt_s;
         ALU_SLTU: cond = lt_u;
         ALU_GEU:  cond = ~lt_u;
         default:  cond = 1'b0;
      endcase
   end

   always_comb begin
      case (alu_op)
         ALU_SUB:  alu_res = operand_a - operand_b;
         ALU_AND:  alu_res = operand_a & operand_b;
         ALU_OR:   alu_res = operand_a | operand_b;
         ALU_XOR:  alu_res = operand_a ^ operand_b;
         ALU_SLT:  alu_res = word_t'(lt_s);
         ALU_SLTU: alu_res = word_t'(lt_u);
         ALU_SLL:  alu_res = operand_a << shamt;
         ALU_SRL:  alu_res = operand_a >> shamt;
         ALU_SRA:  alu_res = word_t'($signed(operand_a) >>> shamt);
         ALU_EQ, ALU_NE, ALU_GE, ALU_GEU: alu_res = word_t'(cond);
         default:  alu_res = operand_a + operand_b;
      endcase
   end

endmodule

`default_nettype wire

// File: source/rv_operand_select.sv
/* Immediate reconstruction, ALU operand muxes and branch target adder */

`timescale 1ns/1ps
`default_nettype none

module rv_operand_select
   import rv_isa_pkg::*;
   import rv_ctrl_pkg::*;
(
   input  word_t      instr,
   input  word_t      pc,
   input  word_t      rs1_data,
   input  word_t      rs2_data,
   input  porta_sel_e porta_sel,
   input  portb_sel_e portb_sel,
   output word_t      operand_a,
   output word_t      operand_b,
   output word_t      branch_target
);

   word_t imm_i;
   word_t imm_s;
   word_t imm_b;
   word_t imm_u;
   word_t imm_j;

   // Sign-extended immediates per format
   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_u = {instr[31:12], 12'b0};
   assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb begin
      case (porta_sel)
         PORTA_PC:   operand_a = pc;
         PORTA_ZERO: operand_a = '0;
         default:    operand_a = rs1_data;
      endcase
   end

   always_comb begin
      case (portb_sel)
         PORTB_IMM_I: operand_b = imm_i;
         PORTB_IMM_S: operand_b = imm_s;
         PORTB_IMM_U: operand_b = imm_u;
         PORTB_IMM_J: operand_b = imm_j;
         default:     operand_b = rs2_data;
      endcase
   end

   // JAL jumps by the J immediate, branches by the B immediate
   assign branch_target = pc + ((instr[6:0] == OPC_JAL) ? imm_j : imm_b);

endmodule

`default_nettype wire

// File: source/rv_control.sv
/* Sequencer, instruction register, decoder and program counter
   One instruction in flight through FETCH, EXECUTE and MEMORY for LW/SW */

`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_control
   import rv_isa_pkg::*;
   import rv_ctrl_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   output word_t      code_addr,
   output logic       code_valid,
   input  word_t      code_rdata,
   input  logic       code_ready,
   output logic       data_we,
   output logic       data_valid,
   input  word_t      data_rdata,
   input  logic       data_ready,
   output word_t      instr,
   output word_t      pc,
   output reg_idx_t   rs1,
   output reg_idx_t   rs2,
   output reg_idx_t   rd,
   output logic       wr_en,
   output word_t      wr_data,
   output porta_sel_e porta_sel,
   output portb_sel_e portb_sel,
   output alu_op_e    alu_op,
   input  word_t      alu_res,
   input  logic       cond,
   input  word_t      branch_target
);

   state_e     state;
   pc_sel_e    pc_sel;
   wb_sel_e    wb_sel;
   logic       rd_write;
   logic       is_load;
   logic       is_store;
   logic [6:0] opcode;
   funct3_e    funct3;
   logic       alt;
   word_t      pc_plus4;
   word_t      pc_next;

   // ==============================
   // Instruction fields
   assign opcode = instr[6:0];
   assign funct3 = instr[FUNCT3_LSB +: 3];
   assign alt    = instr[FUNCT7_LSB + 5];
   assign rs1    = instr[RS1_LSB +: 5];
   assign rs2    = instr[RS2_LSB +: 5];
   assign rd     = instr[RD_LSB +: 5];

   // SUB exists only in the register form
   function automatic alu_op_e alu_group(input funct3_e f3, input logic alt_bit,
                                         input logic sub_en);
      case (f3)
         F3_ADD:  return (sub_en && alt_bit) ? ALU_SUB : ALU_ADD;
         F3_SLL:  return ALU_SLL;
         F3_SLT:  return ALU_SLT;
         F3_SLTU: return ALU_SLTU;
         F3_XOR:  return ALU_XOR;
         F3_SR:   return alt_bit ? ALU_SRA : ALU_SRL;
         F3_OR:   return ALU_OR;
         default: return ALU_AND;
      endcase
   endfunction

   // ==============================
   // Decoder
   always_comb begin
      alu_op    = ALU_ADD;
      porta_sel = PORTA_RS1;
      portb_sel = PORTB_RS2;
      wb_sel    = WB_ALU;
      pc_sel    = PC_SEL_PLUS4;
      rd_write  = 1'b0;
      is_load   = 1'b0;
      is_store  = 1'b0;
      case (opcode)
         OPC_OP: begin
            rd_write = 1'b1;
            alu_op   = alu_group(funct3, alt, 1'b1);
         end
         OPC_OP_IMM: begin
            rd_write  = 1'b1;
            portb_sel = PORTB_IMM_I;
            alu_op    = alu_group(funct3, alt, 1'b0);
         end
         OPC_LUI: begin
            rd_write  = 1'b1;
            porta_sel = PORTA_ZERO;
            portb_sel = PORTB_IMM_U;
         end
         OPC_AUIPC: begin
            rd_write  = 1'b1;
            porta_sel = PORTA_PC;
            portb_sel = PORTB_IMM_U;
         end
         OPC_BRANCH: begin
            pc_sel = PC_SEL_BRANCH;
            case (funct3)
               F3_BEQ:  alu_op = ALU_EQ;
               F3_BNE:  alu_op = ALU_NE;
               F3_BLT:  alu_op = ALU_SLT;
               F3_BGE:  alu_op = ALU_GE;
               F3_BLTU: alu_op = ALU_SLTU;
               F3_BGEU: alu_op = ALU_GEU;
               // Reserved codes fall through as a no-op
               default: pc_sel = PC_SEL_PLUS4;
            endcase
         end
         OPC_JAL: begin
            rd_write = 1'b1;
            wb_sel   = WB_PC_PLUS4;
            pc_sel   = PC_SEL_JAL;
         end
         OPC_JALR: begin
            if (funct3 == F3_ADD) begin
               rd_write  = 1'b1;
               wb_sel    = WB_PC_PLUS4;
               portb_sel = PORTB_IMM_I;
               pc_sel    = PC_SEL_JALR;
            end
         end
         OPC_LOAD: begin
            if (funct3 == F3_WORD) begin
               is_load   = 1'b1;
               rd_write  = 1'b1;
               wb_sel    = WB_LOAD;
               portb_sel = PORTB_IMM_I;
            end
         end
         OPC_STORE: begin
            if (funct3 == F3_WORD) begin
               is_store  = 1'b1;
               portb_sel = PORTB_IMM_S;
            end
         end
         default: ;
      endcase
   end

   // ==============================
   // Next PC and write-back
   assign pc_plus4 = pc + word_t'(4);

   always_comb begin
      case (pc_sel)
         PC_SEL_BRANCH: pc_next = cond ? branch_target : pc_plus4;
         PC_SEL_JAL:    pc_next = branch_target;
         PC_SEL_JALR:   pc_next = {alu_res[`RV_XLEN-1:1], 1'b0};
         default:       pc_next = pc_plus4;
      endcase
   end

   always_comb begin
      case (wb_sel)
         WB_PC_PLUS4: wr_data = pc_plus4;
         WB_LOAD:     wr_data = data_rdata;
         default:     wr_data = alu_res;
      endcase
   end

   // LW writes in its MEMORY ready cycle and everything else in EXECUTE
   assign wr_en = rd_write & (((state == ST_EXECUTE) & ~is_load) |
                              ((state == ST_MEMORY) & data_ready));

   // ==============================
   // Sequencer
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_FETCH;
         pc    <= `RV_RESET_PC;
         instr <= '0;
      end else begin
         case (state)
            ST_FETCH: begin
               if (code_ready) begin
                  instr <= code_rdata;
                  state <= ST_EXECUTE;
               end
            end
            ST_EXECUTE: begin
               if (is_load || is_store) begin
                  state <= ST_MEMORY;
               end else begin
                  pc    <= pc_next;
                  state <= ST_FETCH;
               end
            end
            ST_MEMORY: begin
               if (data_ready) begin
                  pc    <= pc_next;
                  state <= ST_FETCH;
               end
            end
            default: state <= ST_FETCH;
         endcase
      end
   end

   // Memory requests come straight from the state
   assign code_addr  = pc;
   assign code_valid = (state == ST_FETCH);
   assign data_valid = (state == ST_MEMORY);
   assign data_we    = data_valid & is_store;

   // Data request held until accepted, address taken from the ALU
   data_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (data_valid && !data_ready) |=>
         (data_valid && $stable(data_we) && $stable(alu_res)));

   // Fetch request held until accepted
   code_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (code_valid && !code_ready) |=> (code_valid && $stable(code_addr)));

endmodule

`default_nettype wire

// File: source/rv_core.sv
/* Top level of the multi-cycle RV32I core
   Control and datapath wired to the code and data memory ports */

`timescale 1ns/1ps
`default_nettype none

module rv_core
   import rv_isa_pkg::*;
   import rv_ctrl_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   output word_t code_addr,
   output logic  code_valid,
   input  word_t code_rdata,
   input  logic  code_ready,
   output word_t data_addr,
   output word_t data_wdata,
   output logic  data_we,
   output logic  data_valid,
   input  word_t data_rdata,
   input  logic  data_ready
);

   word_t      instr;
   word_t      pc;
   reg_idx_t   rs1;
   reg_idx_t   rs2;
   reg_idx_t   rd;
   logic       wr_en;
   word_t      wr_data;
   porta_sel_e porta_sel;
   portb_sel_e portb_sel;
   alu_op_e    alu_op;
   word_t      alu_res;
   logic       cond;
   word_t      branch_target;
   word_t      operand_a;
   word_t      operand_b;
   word_t      rs1_data;
   word_t      rs2_data;

   // Load/store address from the ALU, store data from rs2
   assign data_addr  = alu_res;
   assign data_wdata = rs2_data;

   rv_control u_control (
      .clk           (clk),
      .rst_n         (rst_n),
      .code_addr     (code_addr),
      .code_valid    (code_valid),
      .code_rdata    (code_rdata),
      .code_ready    (code_ready),
      .data_we       (data_we),
      .data_valid    (data_valid),
      .data_rdata    (data_rdata),
      .data_ready    (data_ready),
      .instr         (instr),
      .pc            (pc),
      .rs1           (rs1),
      .rs2           (rs2),
      .rd            (rd),
      .wr_en         (wr_en),
      .wr_data       (wr_data),
      .porta_sel     (porta_sel),
      .portb_sel     (portb_sel),
      .alu_op        (alu_op),
      .alu_res       (alu_res),
      .cond          (cond),
      .branch_target (branch_target)
   );

   rv_operand_select u_operand_select (
      .instr         (instr),
      .pc            (pc),
      .rs1_data      (rs1_data),
      .rs2_data      (rs2_data),
      .porta_sel     (porta_sel),
      .portb_sel     (portb_sel),
      .operand_a     (operand_a),
      .operand_b     (operand_b),
      .branch_target (branch_target)
   );

   rv_alu u_alu (
      .alu_op    (alu_op),
      .operand_a (operand_a),
      .operand_b (operand_b),
      .alu_res   (alu_res),
      .cond      (cond)
   );

   rv_regfile u_regfile (
      .clk      (clk),
      .rst_n    (rst_n),
      .rs1      (rs1),
      .rs2      (rs2),
      .rd       (rd),
      .wr_en    (wr_en),
      .wr_data  (wr_data),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data)
   );

endmodule

`default_nettype wire

// File: sim/tb_rv_core.sv
/* Directed testbench for the RV32I core: code and data memory models,
   program assembler, tests, value checks and watchdog */

`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module tb_rv_core
   import rv_isa_pkg::*;
();

   localparam int    CLK_PERIOD  = 40;
   localparam int    MEM_WORDS   = 256;
   localparam word_t OPND_BASE   = 32'h0000_0100;
   localparam word_t RES_BASE    = 32'h0000_0200;
   localparam word_t MARKER_ADDR = 32'h0000_03FC;
   localparam word_t FILL_MASK   = 32'h5A5A_0000;
   localparam word_t NOP         = 32'h0000_0013;

   // Upper bounds on instructions per test, marker store included
   localparam int ALU_INSTRS     = 44;
   localparam int UPPER_INSTRS   = 6;
   localparam int BRANCH_INSTRS  = 58;
   localparam int JUMP_INSTRS    = 8;
   localparam int NOP_INSTRS     = 10;
   localparam int CPI_WORST      = 12;
   localparam int RESET_CYCLES   = 4;
   localparam int TIMEOUT_CYCLES = (ALU_INSTRS + UPPER_INSTRS + BRANCH_INSTRS +
                                    JUMP_INSTRS + NOP_INSTRS) * CPI_WORST + 5 * RESET_CYCLES;

   logic  clk;
   logic  rst_n;
   word_t code_addr;
   logic  code_valid;
   word_t code_rdata;
   logic  code_ready;
   word_t data_addr;
   word_t data_wdata;
   logic  data_we;
   logic  data_valid;
   word_t data_rdata;
   logic  data_ready;

   word_t code_mem [MEM_WORDS];
   word_t data_mem [MEM_WORDS];
   word_t prog_pc;
   word_t exp_fetch_q [$];
   word_t exp_addr_q [$];
   word_t exp_data_q [$];
   word_t fetch_q [$];
   word_t st_addr_q [$];
   word_t st_data_q [$];
   logic  marker_seen;
   int    code_wait;
   int    data_wait;

   // Request snapshot while valid waits for ready
   logic  code_pending;
   logic  data_pending;
   word_t held_code_addr;
   word_t held_data_addr;
   word_t held_data_wdata;
   logic  held_data_we;

   rv_core DUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .code_addr  (code_addr),
      .code_valid (code_valid),
      .code_rdata (code_rdata),
      .code_ready (code_ready),
      .data_addr  (data_addr),
      .data_wdata (data_wdata),
      .data_we    (data_we),
      .data_valid (data_valid),
      .data_rdata (data_rdata),
      .data_ready (data_ready)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // ==============================
   // Checks
   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
         $display("Testbench failed");
         $fatal(1, "Word mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
         $display("Testbench failed");
         $fatal(1, "Bit mismatch");
      end
   endtask

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1, "Run stopped");
   endtask

   // ==============================
   // Memory models
   // Ready rises 0 to 3 cycles after the request is seen
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         code_ready <= 1'b0;
         code_rdata <= '0;
         code_wait  <= 0;
      end else if (code_valid && code_ready) begin
         code_ready <= 1'b0;
         fetch_q.push_back(code_addr);
      end else if (code_valid) begin
         if (code_wait == 0) begin
            code_ready <= 1'b1;
            code_rdata <= code_mem[code_addr[9:2]];
            code_wait  <= $urandom % 4;
         end else begin
            code_wait <= code_wait - 1;
         end
      end
   end

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         data_ready <= 1'b0;
         data_rdata <= '0;
         data_wait  <= 0;
      end else if (data_valid && data_ready) begin
         data_ready <= 1'b0;
         if (data_we) begin
            data_mem[data_addr[9:2]] = data_wdata;
            st_addr_q.push_back(data_addr);
            st_data_q.push_back(data_wdata);
            if (data_addr == MARKER_ADDR) begin
               marker_seen = 1'b1;
            end
         end
      end else if (data_valid) begin
         if (data_wait == 0) begin
            data_ready <= 1'b1;
            data_rdata <= data_mem[data_addr[9:2]];
            data_wait  <= $urandom % 4;
         end else begin
            data_wait <= data_wait - 1;
         end
      end
   end

   // Requests must hold still until accepted
   always @(posedge clk) begin
      if (rst_n && code_pending) begin
         check_bit("code_valid", code_valid, 1'b1);
         check_word("code_addr", code_addr, held_code_addr);
      end
      if (rst_n && data_pending) begin
         check_bit("data_valid", data_valid, 1'b1);
         check_word("data_addr", data_addr, held_data_addr);
         check_word("data_wdata", data_wdata, held_data_wdata);
         check_bit("data_we", data_we, held_data_we);
      end
      code_pending    <= rst_n && code_valid && !code_ready;
      data_pending    <= rst_n && data_valid && !data_ready;
      held_code_addr  <= code_addr;
      held_data_addr  <= data_addr;
      held_data_wdata <= data_wdata;
      held_data_we    <= data_we;
   end

   // ==============================
   // Instruction encoders
   function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input funct3_e f3, input reg_idx_t rd);
      return {f7, rs2, rs1, f3, rd, OPC_OP};
   endfunction

   function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                    input funct3_e f3, input reg_idx_t rd, input opcode_e opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input funct3_e f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
   endfunction

   function automatic word_t b_type(input logic [12:0] off, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input funct3_e f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
   endfunction

   function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                    input opcode_e opc);
      return {imm, rd, opc};
   endfunction

   function automatic word_t j_type(input logic [20:0] off, input reg_idx_t rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
   endfunction

   function automatic word_t load_word(input reg_idx_t rd, input word_t addr);
      return i_type(addr[11:0], 5'd0, F3_WORD, rd, OPC_LOAD);
   endfunction

   function automatic word_t store_word(input reg_idx_t rs2, input word_t addr);
      return s_type(addr[11:0], rs2, 5'd0, F3_WORD);
   endfunction

   // ==============================
   // Expected values from the RV32I rules
   function automatic word_t rv32_result(input funct3_e f3, input logic alt,
                                         input word_t a, input word_t b);
      case (f3)
         F3_ADD:  return alt ? a - b : a + b;
         F3_SLL:  return a << b[4:0];
         F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
         F3_XOR:  return a ^ b;
         F3_SR:   return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
         F3_OR:   return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branch_taken(input funct3_e f3, input word_t a, input word_t b);
      case (f3)
         F3_BEQ:  return a == b;
         F3_BNE:  return a != b;
         F3_BLT:  return $signed(a) < $signed(b);
         F3_BGE:  return $signed(a) >= $signed(b);
         F3_BLTU: return a < b;
         default: return a >= b;
      endcase
   endfunction

   // {alt, funct3} for ADD SUB AND OR XOR SLT SLTU SLL SRL SRA
   function automatic logic [3:0] alu_case(input int k);
      case (k)
         0:       return {1'b0, F3_ADD};
         1:       return {1'b1, F3_ADD};
         2:       return {1'b0, F3_AND};
         3:       return {1'b0, F3_OR};
         4:       return {1'b0, F3_XOR};
         5:       return {1'b0, F3_SLT};
         6:       return {1'b0, F3_SLTU};
         7:       return {1'b0, F3_SLL};
         8:       return {1'b0, F3_SR};
         default: return {1'b1, F3_SR};
      endcase
   endfunction

   // ==============================
   // Program builder and run control
   task automatic emit(input word_t instr, input logic fetched);
      code_mem[prog_pc[9:2]] = instr;
      if (fetched) begin
         exp_fetch_q.push_back(prog_pc);
      end
      prog_pc += 4;
   endtask

   task automatic expect_store(input word_t addr, input word_t data);
      exp_addr_q.push_back(addr);
      exp_data_q.push_back(data);
   endtask

   task automatic check_reset_outputs();
      check_bit("code_valid", code_valid, 1'b1);
      check_bit("data_valid", data_valid, 1'b0);
      check_word("code_addr", code_addr, `RV_RESET_PC);
   endtask

   // Program is loaded while the core sits in reset
   task automatic enter_reset();
      @(posedge clk);
      rst_n <= 1'b0;
      @(negedge clk);
      check_reset_outputs();
      fetch_q.delete();
      st_addr_q.delete();
      st_data_q.delete();
      exp_fetch_q.delete();
      exp_addr_q.delete();
      exp_data_q.delete();
      marker_seen = 1'b0;
      prog_pc = `RV_RESET_PC;
      for (int i = 0; i < MEM_WORDS; i++) begin
         code_mem[i] = '0;
         data_mem[i] = word_t'(i * 4) ^ FILL_MASK;
      end
   endtask

   task automatic compare_results();
      check_word("store_count", word_t'(st_addr_q.size() - 1), word_t'(exp_addr_q.size()));
      foreach (exp_addr_q[i]) begin
         check_word($sformatf("store_addr[%0d]", i), st_addr_q[i], exp_addr_q[i]);
         check_word($sformatf("store_data[%0d]", i), st_data_q[i], exp_data_q[i]);
      end
      if (fetch_q.size() < exp_fetch_q.size()) begin
         report_failure("Fewer instruction fetches than the program needs");
      end
      foreach (exp_fetch_q[i]) begin
         check_word($sformatf("fetch_addr[%0d]", i), fetch_q[i], exp_fetch_q[i]);
      end
   endtask

   // Marker store, then a jump-to-self that parks the core
   task automatic leave_reset_and_run();
      emit(store_word(5'd0, MARKER_ADDR), 1'b1);
      emit(j_type(21'd0, 5'd0), 1'b0);
      @(posedge clk);
      @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_reset_outputs();
      while (!marker_seen) begin
         @(posedge clk);
      end
      compare_results();
   endtask

   // ==============================
   // Tests
   task automatic test_alu_ops();
      word_t       a;
      word_t       b;
      word_t       opb;
      word_t       res;
      logic [3:0]  sel;
      logic [11:0] imm12;
      enter_reset();
      a = $urandom;
      b = $urandom;
      data_mem[OPND_BASE[9:2]]     = a;
      data_mem[OPND_BASE[9:2] + 1] = b;
      emit(load_word(5'd1, OPND_BASE), 1'b1);
      emit(load_word(5'd2, OPND_BASE + 4), 1'b1);
      for (int k = 0; k < 19; k++) begin
         if (k < 10) begin
            sel = alu_case(k);
            emit(r_type(sel[3] ? F7_ALT : 7'b0, 5'd2, 5'd1, sel[2:0], 5'd3), 1'b1);
            res = rv32_result(sel[2:0], sel[3], a, b);
         end else begin
            // Immediate forms have no SUB
            sel   = alu_case((k == 10) ? 0 : k - 9);
            imm12 = 12'($urandom);
            if (sel[2:0] == F3_SLL || sel[2:0] == F3_SR) begin
               imm12 = {sel[3] ? F7_ALT : 7'b0, imm12[4:0]};
            end
            opb = {{20{imm12[11]}}, imm12};
            emit(i_type(imm12, 5'd1, sel[2:0], 5'd3, OPC_OP_IMM), 1'b1);
            res = rv32_result(sel[2:0], sel[3], a, opb);
         end
         emit(store_word(5'd3, RES_BASE + 4 * k), 1'b1);
         expect_store(RES_BASE + 4 * k, res);
      end
      // Write to x0 must be lost
      emit(r_type(7'b0, 5'd2, 5'd1, F3_ADD, 5'd0), 1'b1);
      emit(store_word(5'd0, RES_BASE + 76), 1'b1);
      expect_store(RES_BASE + 76, '0);
      leave_reset_and_run();
   endtask

   task automatic test_upper_imm();
      logic [19:0] u1;
      logic [19:0] u2;
      word_t       auipc_pc;
      enter_reset();
      u1 = 20'($urandom);
      u2 = 20'($urandom);
      emit(u_type(u1, 5'd5, OPC_LUI), 1'b1);
      emit(store_word(5'd5, RES_BASE), 1'b1);
      expect_store(RES_BASE, {u1, 12'h000});
      auipc_pc = prog_pc;
      emit(u_type(u2, 5'd6, OPC_AUIPC), 1'b1);
      emit(store_word(5'd6, RES_BASE + 4), 1'b1);
      expect_store(RES_BASE + 4, {u2, 12'h000} + auipc_pc);
      leave_reset_and_run();
   endtask

   // Each branch against (x3,x4), (x4,x3) and (x4,x4)
   task automatic test_branches();
      funct3_e  f3;
      reg_idx_t rsa;
      reg_idx_t rsb;
      word_t    va;
      word_t    vb;
      logic     taken;
      enter_reset();
      data_mem[OPND_BASE[9:2]]     = 32'hFFFF_FFFD;
      data_mem[OPND_BASE[9:2] + 1] = 32'h0000_0002;
      emit(load_word(5'd3, OPND_BASE), 1'b1);
      emit(load_word(5'd4, OPND_BASE + 4), 1'b1);
      for (int f = 0; f < 6; f++) begin
         for (int p = 0; p < 3; p++) begin
            // Branch codes are 0, 1, then 4 to 7
            f3    = funct3_e'((f < 2) ? f : f + 2);
            rsa   = (p == 0) ? 5'd3 : 5'd4;
            rsb   = (p == 1) ? 5'd3 : 5'd4;
            va    = (rsa == 5'd3) ? 32'hFFFF_FFFD : 32'h0000_0002;
            vb    = (rsb == 5'd3) ? 32'hFFFF_FFFD : 32'h0000_0002;
            taken = branch_taken(f3, va, vb);
            emit(b_type(13'd12, rsb, rsa, f3), 1'b1);
            emit(NOP, !taken);
            emit(NOP, !taken);
         end
      end
      leave_reset_and_run();
   endtask

   task automatic test_jumps();
      word_t jal_pc;
      word_t jalr_pc;
      word_t target;
      word_t base;
      enter_reset();
      jal_pc = prog_pc;
      emit(j_type(21'd16, 5'd7), 1'b1);
      emit(NOP, 1'b0);
      emit(NOP, 1'b0);
      emit(NOP, 1'b0);
      emit(store_word(5'd7, RES_BASE), 1'b1);
      expect_store(RES_BASE, jal_pc + 4);
      // Odd sum, bit 0 must be cleared
      jalr_pc = prog_pc + 4;
      target  = jalr_pc + 12;
      base    = target - 4;
      emit(i_type(base[11:0], 5'd0, F3_ADD, 5'd8, OPC_OP_IMM), 1'b1);
      emit(i_type(12'd5, 5'd8, F3_ADD, 5'd9, OPC_JALR), 1'b1);
      emit(NOP, 1'b0);
      emit(NOP, 1'b0);
      emit(store_word(5'd9, RES_BASE + 4), 1'b1);
      expect_store(RES_BASE + 4, jalr_pc + 4);
      leave_reset_and_run();
   endtask

   task automatic test_no_ops();
      word_t v;
      enter_reset();
      v = $urandom;
      data_mem[OPND_BASE[9:2]] = v;
      emit(load_word(5'd1, OPND_BASE), 1'b1);
      emit(store_word(5'd1, RES_BASE), 1'b1);
      expect_store(RES_BASE, v);
      emit(32'h0FF0_000F, 1'b1);
      emit(32'h0000_100F, 1'b1);
      // Unknown opcode with rd = x1
      emit(32'h0000_00FF, 1'b1);
      // Byte load and byte store are dropped
      emit(i_type(OPND_BASE[11:0], 5'd0, 3'b000, 5'd1, OPC_LOAD), 1'b1);
      emit(s_type(12'h204, 5'd0, 5'd0, 3'b000), 1'b1);
      emit(store_word(5'd1, RES_BASE + 8), 1'b1);
      expect_store(RES_BASE + 8, v);
      leave_reset_and_run();
   endtask

   // ==============================
   // Main sequence and watchdog
   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      code_rdata = '0;
      code_ready = 1'b0;
      data_rdata = '0;
      data_ready = 1'b0;
      void'($urandom(32'h4b2dd879));
      test_alu_ops();
      test_upper_imm();
      test_branches();
      test_jumps();
      test_no_ops();
      $display("Testbench passed");
      $finish;
   end

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $fatal(1, "Watchdog expired");
   end

endmodule

`default_nettype wire

// File: sim.f
+incdir+source
source/rv_isa_pkg.sv
source/rv_ctrl_pkg.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_operand_select.sv
source/rv_control.sv
source/rv_core.sv
sim/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - source
    files:
      - source/rv_isa_pkg.sv
      - source/rv_ctrl_pkg.sv
      - source/rv_regfile.sv
      - source/rv_alu.sv
      - source/rv_operand_select.sv
      - source/rv_control.sv
      - source/rv_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - sim/tb_rv_core.sv
